// File: ffe_mac.sv
// execute stage of the FFE, two-stage multiply-accumulate with arithmetic shift and saturation
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_config.svh"

module ffe_mac (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    // window from the decode stage
    input  wire rx_dsp_pkg::tap_window_t   window_i,
    input  wire logic                      window_valid_i,
    // filter configuration
    input  wire rx_dsp_pkg::weight_set_t   weights_i,
    // equalized sample to the slicer
    output rx_dsp_pkg::eq_sample_t         eq_o
);

    // clamp limits of the signed result, held at accumulator width
    localparam logic signed [`RX_ACC_WIDTH-1:0] SAT_MAX =
        `RX_ACC_WIDTH'((1 << (`RX_RESULT_WIDTH - 1)) - 1);
    localparam logic signed [`RX_ACC_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    // stage one registers
    logic                               s1_valid_q;
    rx_dsp_pkg::shift_t                 s1_shift_q;
    logic signed [`RX_PROD_WIDTH-1:0]   s1_prod_q [`RX_FFE_LENGTH];

    // stage two combinational path
    logic signed [`RX_ACC_WIDTH-1:0]    acc_sum;
    logic signed [`RX_ACC_WIDTH-1:0]    acc_shifted;
    rx_dsp_pkg::result_t                sat_value;

    // stage one
    // weights and shift are sampled here, so a later write cannot
    // reach a sample that has already moved on
    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= window_valid_i;
        end
        if (window_valid_i) begin
            for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
                s1_prod_q[k] <= $signed(window_i[k]) * $signed(weights_i.tap[k]);
            end
            s1_shift_q <= weights_i.shift;
        end
    end

    // sum of products at full precision
    always_comb begin
        acc_sum = '0;
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            acc_sum = acc_sum + s1_prod_q[k];
        end
    end

    // arithmetic shift rounds toward negative infinity
    assign acc_shifted = acc_sum >>> s1_shift_q;

    // clamp into the signed result range
    always_comb begin
        if (acc_shifted > SAT_MAX) begin
            sat_value = SAT_MAX[`RX_RESULT_WIDTH-1:0];
        end else if (acc_shifted < SAT_MIN) begin
            sat_value = SAT_MIN[`RX_RESULT_WIDTH-1:0];
        end else begin
            sat_value = acc_shifted[`RX_RESULT_WIDTH-1:0];
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            eq_o.valid <= 1'b0;
        end else begin
            eq_o.valid <= s1_valid_q;
        end
        if (s1_valid_q) begin
            eq_o.value <= sat_value;
        end
    end

endmodule

`default_nettype wire

// File: ffe_tap_window.sv
// decode stage of the FFE, shifts valid ADC codes into the tap delay line
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_config.svh"

module ffe_tap_window (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    // ADC sample stream
    input  wire rx_dsp_pkg::code_t       code_i,
    input  wire logic                    code_valid_i,
    // window of the most recent codes
    output rx_dsp_pkg::tap_window_t      window_o,
    output logic                         window_valid_o
);

    // one-cycle strobe per new window
    always_ff @(posedge clk) begin
        if (rst_i) begin
            window_valid_o <= 1'b0;
        end else begin
            window_valid_o <= code_valid_i;
        end
    end

    // delay line only moves on a valid code, so gaps hold the window
    always_ff @(posedge clk) begin
        if (rst_i) begin
            window_o <= '0;
        end else if (code_valid_i) begin
            // age every tap by one place
            for (int k = `RX_FFE_LENGTH - 1; k > 0; k--) begin
                window_o[k] <= window_o[k-1];
            end
            // newest code enters at tap 0
            window_o[0] <= code_i;
        end
    end

endmodule

`default_nettype wire

// File: ffe_weight_bank.sv
// FFE configuration registers, loaded by host write strobes and read as one packed weight set
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_config.svh"

module ffe_weight_bank (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    // tap weight write port
    input  wire logic                          wt_we_i,
    input  wire logic [`RX_WT_ADDR_WIDTH-1:0]  wt_addr_i,
    input  wire rx_dsp_pkg::weight_t           wt_data_i,
    // shift write port
    input  wire logic                          shift_we_i,
    input  wire rx_dsp_pkg::shift_t            shift_data_i,
    // current configuration
    output rx_dsp_pkg::weight_set_t            weights_o
);

    // per-tap write enables from the address decode
    logic [`RX_FFE_LENGTH-1:0] tap_we;

    // addresses at or beyond the tap count match no tap and are dropped
    always_comb begin
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            tap_we[k] = wt_we_i && (wt_addr_i == `RX_WT_ADDR_WIDTH'(k));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // identity filter: unit weight on the newest tap, no shift
            for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
                weights_o.tap[k] <= (k == 0) ? rx_dsp_pkg::weight_t'(1)
                                             : rx_dsp_pkg::weight_t'(0);
            end
            weights_o.shift <= '0;
        end else begin
            for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
                if (tap_we[k]) begin
                    weights_o.tap[k] <= wt_data_i;
                end
            end
            if (shift_we_i) begin
                weights_o.shift <= shift_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
rx_dsp_pkg.sv
ffe_weight_bank.sv
ffe_tap_window.sv
ffe_mac.sv
rx_slicer.sv
rx_dsp_top.sv
tb_rx_dsp.sv

// File: run.sh
#!/bin/sh
# build the receiver DSP testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_rx_dsp \
    -o sim_rx_dsp > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_rx_dsp > sim.log 2>&1 \
    || { cat sim.log; echo "simulation did not complete"; exit 1; }

cat sim.log

grep -q '>>> FAIL' sim.log && { echo "simulation reported failure"; exit 1; }

grep -q '>>> PASS' sim.log || { echo "no result found in sim.log"; exit 1; }

exit 0

// File: rx_dsp_config.svh
// build-time sizes of the receiver DSP back end, included by the package and the RTL
`ifndef RX_DSP_CONFIG_SVH
`define RX_DSP_CONFIG_SVH

// number of equalizer taps
`define RX_FFE_LENGTH 4

// signed ADC code width
`define RX_CODE_WIDTH 8

// signed tap weight width
`define RX_WEIGHT_WIDTH 8

// right-shift amount applied after the sum
`define RX_SHIFT_WIDTH 4

// signed equalized output width
`define RX_RESULT_WIDTH 10

// full-precision product and accumulator widths
// two guard bits cover the sum of four products
`define RX_PROD_WIDTH (`RX_CODE_WIDTH + `RX_WEIGHT_WIDTH)
`define RX_ACC_WIDTH (`RX_CODE_WIDTH + `RX_WEIGHT_WIDTH + 2)

// host weight address, one bit wider than the tap index so that
// writes to addresses past the last tap can be seen and dropped
`define RX_WT_ADDR_WIDTH 3

`endif

// File: rx_dsp_pkg.sv
// shared types of the receiver DSP, referenced by scoped name from the RTL and testbench
`default_nettype none

`include "rx_dsp_config.svh"

package rx_dsp_pkg;

    // one signed ADC code
    typedef logic signed [`RX_CODE_WIDTH-1:0] code_t;

    // one signed tap weight
    typedef logic signed [`RX_WEIGHT_WIDTH-1:0] weight_t;

    // arithmetic right-shift amount
    typedef logic [`RX_SHIFT_WIDTH-1:0] shift_t;

    // saturated equalizer output
    typedef logic signed [`RX_RESULT_WIDTH-1:0] result_t;

    // tap delay line contents
    // element 0 holds the newest code, the highest index the oldest
    typedef code_t [`RX_FFE_LENGTH-1:0] tap_window_t;

    // complete filter configuration as seen by the MAC
    typedef struct packed {
        weight_t [`RX_FFE_LENGTH-1:0] tap;
        shift_t                       shift;
    } weight_set_t;

    // equalized sample handed from the MAC to the slicer
    typedef struct packed {
        logic    valid;
        result_t value;
    } eq_sample_t;

endpackage

`default_nettype wire

// File: rx_dsp_top.sv
// top level of the receiver DSP back end, ADC codes in, equalized value and decided bit out
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_config.svh"

module rx_dsp_top (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    // ADC sample stream
    input  wire rx_dsp_pkg::code_t             code_i,
    input  wire logic                          code_valid_i,
    // host configuration writes
    input  wire logic                          wt_we_i,
    input  wire logic [`RX_WT_ADDR_WIDTH-1:0]  wt_addr_i,
    input  wire rx_dsp_pkg::weight_t           wt_data_i,
    input  wire logic                          shift_we_i,
    input  wire rx_dsp_pkg::shift_t            shift_data_i,
    // slicer outputs, four cycles after the code
    output logic                               data_o,
    output logic                               data_valid_o,
    output rx_dsp_pkg::result_t                eq_o
);

    rx_dsp_pkg::weight_set_t  weights;
    rx_dsp_pkg::tap_window_t  window;
    logic                     window_valid;
    rx_dsp_pkg::eq_sample_t   eq;

    // configuration state beside the datapath
    ffe_weight_bank u_weight_bank (
        .clk          (clk),
        .rst_i        (rst_i),
        .wt_we_i      (wt_we_i),
        .wt_addr_i    (wt_addr_i),
        .wt_data_i    (wt_data_i),
        .shift_we_i   (shift_we_i),
        .shift_data_i (shift_data_i),
        .weights_o    (weights)
    );

    // decode, one cycle
    ffe_tap_window u_tap_window (
        .clk            (clk),
        .rst_i          (rst_i),
        .code_i         (code_i),
        .code_valid_i   (code_valid_i),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    // execute, two cycles
    ffe_mac u_mac (
        .clk            (clk),
        .rst_i          (rst_i),
        .window_i       (window),
        .window_valid_i (window_valid),
        .weights_i      (weights),
        .eq_o           (eq)
    );

    // result, one cycle
    rx_slicer u_slicer (
        .clk          (clk),
        .rst_i        (rst_i),
        .eq_i         (eq),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .eq_o         (eq_o)
    );

endmodule

`default_nettype wire

// File: rx_slicer.sv
// result stage of the receiver, registers the equalized value and decides the data bit by its sign
`timescale 1ns/1ps
`default_nettype none

module rx_slicer (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    // equalized sample from the MAC
    input  wire rx_dsp_pkg::eq_sample_t    eq_i,
    // decided bit and its soft value
    output logic                           data_o,
    output logic                           data_valid_o,
    output rx_dsp_pkg::result_t            eq_o
);

    // strictly positive decides 1, zero falls to 0
    logic bit_d;

    assign bit_d = ($signed(eq_i.value) > 0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_valid_o <= 1'b0;
            data_o       <= 1'b0;
        end else begin
            data_valid_o <= eq_i.valid;
            if (eq_i.valid) begin
                data_o <= bit_d;
            end
        end
    end

    // soft value holds between samples like the bit
    always_ff @(posedge clk) begin
        if (eq_i.valid) begin
            eq_o <= eq_i.value;
        end
    end

endmodule

`default_nettype wire

// File: tb_rx_dsp.sv
// self-checking testbench for rx_dsp_top, runs the FFE and slicer against a reference equalizer
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_config.svh"

module tb_rx_dsp;

    // stimulus lengths, in samples
    localparam int N_IDENT = 40;
    localparam int N_RAND = 200;
    localparam int N_SHIFT = 40;
    localparam int N_SAT = 8;
    localparam int N_GAP = 120;
    localparam int N_ZERO = 12;
    // weight loads and drains, generous per section
    localparam int N_SECTIONS = 16;
    localparam int SECTION_CYCLES = 30;
    localparam int STIM_CYCLES = 8 + 5 + N_IDENT + N_RAND + 4 * N_SHIFT + 4 * N_SAT
                               + N_GAP + N_ZERO + N_SECTIONS * SECTION_CYCLES;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES * 2 + 200;
    // code in to data_valid_o out, in clock cycles
    localparam int OUT_LATENCY = 4;

    // expected slicer output for one code
    typedef struct packed {
        logic                data;
        rx_dsp_pkg::result_t value;
        int                  sent_cycle;
    } expect_t;

    logic                            clk;
    logic                            rst_i;
    rx_dsp_pkg::code_t               code_i;
    logic                            code_valid_i;
    logic                            wt_we_i;
    logic [`RX_WT_ADDR_WIDTH-1:0]    wt_addr_i;
    rx_dsp_pkg::weight_t             wt_data_i;
    logic                            shift_we_i;
    rx_dsp_pkg::shift_t              shift_data_i;
    logic                            data_o;
    logic                            data_valid_o;
    rx_dsp_pkg::result_t             eq_o;

    // reference state
    rx_dsp_pkg::tap_window_t         model_win;
    rx_dsp_pkg::weight_set_t         model_wts;
    expect_t                         expect_q[$];
    expect_t                         exp_e;
    rx_dsp_pkg::eq_sample_t          observed;
    integer                          seed;
    int                              error_count;
    int                              check_count;
    int                              cycle_count;

    rx_dsp_top uut (
        .clk          (clk),
        .rst_i        (rst_i),
        .code_i       (code_i),
        .code_valid_i (code_valid_i),
        .wt_we_i      (wt_we_i),
        .wt_addr_i    (wt_addr_i),
        .wt_data_i    (wt_data_i),
        .shift_we_i   (shift_we_i),
        .shift_data_i (shift_data_i),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .eq_o         (eq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // free-running cycle count, stamps each code and its output
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // sum of products, floor shift, clamp, then sign decision
    function automatic expect_t equalize_reference(input rx_dsp_pkg::tap_window_t win,
                                                   input rx_dsp_pkg::weight_set_t ws);
        longint  acc;
        longint  lim_max;
        longint  lim_min;
        expect_t e;
        lim_max = (longint'(1) << (`RX_RESULT_WIDTH - 1)) - 1;
        lim_min = -lim_max - 1;
        acc = 0;
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            acc = acc + longint'($signed(win[k])) * longint'($signed(ws.tap[k]));
        end
        acc = acc >>> ws.shift;
        if (acc > lim_max) begin
            acc = lim_max;
        end else if (acc < lim_min) begin
            acc = lim_min;
        end
        e.value = rx_dsp_pkg::result_t'(acc);
        e.data = (acc > 0);
        e.sent_cycle = 0;
        return e;
    endfunction

    function automatic rx_dsp_pkg::weight_set_t identity_weights(input rx_dsp_pkg::shift_t s);
        rx_dsp_pkg::weight_set_t ws;
        ws = '0;
        ws.tap[0] = rx_dsp_pkg::weight_t'(1);
        ws.shift = s;
        return ws;
    endfunction

    function automatic rx_dsp_pkg::weight_set_t uniform_weights(input rx_dsp_pkg::weight_t w);
        rx_dsp_pkg::weight_set_t ws;
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            ws.tap[k] = w;
        end
        ws.shift = '0;
        return ws;
    endfunction

    function automatic rx_dsp_pkg::weight_set_t random_weights(input rx_dsp_pkg::shift_t s);
        rx_dsp_pkg::weight_set_t ws;
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            ws.tap[k] = rx_dsp_pkg::weight_t'($random(seed));
        end
        ws.shift = s;
        return ws;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
            error_count++;
        end
    endtask

    // one host write per tap, one to an unused address, then the shift
    task automatic load_weights(input rx_dsp_pkg::weight_set_t ws);
        for (int k = 0; k < `RX_FFE_LENGTH; k++) begin
            @(posedge clk);
            #1;
            wt_we_i = 1'b1;
            wt_addr_i = `RX_WT_ADDR_WIDTH'(k);
            wt_data_i = ws.tap[k];
        end
        // out of range, bank must drop it
        @(posedge clk);
        #1;
        wt_addr_i = `RX_WT_ADDR_WIDTH'(`RX_FFE_LENGTH);
        wt_data_i = rx_dsp_pkg::weight_t'(8'h55);
        @(posedge clk);
        #1;
        wt_we_i = 1'b0;
        shift_we_i = 1'b1;
        shift_data_i = ws.shift;
        @(posedge clk);
        #1;
        shift_we_i = 1'b0;
        model_wts = ws;
    endtask

    task automatic send_code(input rx_dsp_pkg::code_t code, input logic valid);
        expect_t entry;
        @(posedge clk);
        #1;
        code_i = code;
        code_valid_i = valid;
        if (valid) begin
            for (int k = `RX_FFE_LENGTH - 1; k > 0; k--) begin
                model_win[k] = model_win[k-1];
            end
            model_win[0] = code;
            entry = equalize_reference(model_win, model_wts);
            entry.sent_cycle = cycle_count;
            expect_q.push_back(entry);
        end
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_code(rx_dsp_pkg::code_t'($random(seed)), 1'b1);
        end
    endtask

    // stop the stream and let every sample leave the pipeline
    task automatic drain_pipeline();
        int waited;
        @(posedge clk);
        #1;
        code_valid_i = 1'b0;
        waited = 0;
        while (expect_q.size() != 0 && waited < 16) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("missing outputs: %0d samples never came out of the DUT", expect_q.size());
            error_count += expect_q.size();
            expect_q.delete();
        end
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        observed.valid = data_valid_o;
        observed.value = eq_o;
        if (!rst_i && observed.valid) begin
            if (expect_q.size() == 0) begin
                $display("unexpected output: data_valid_o with no sample pending at %0t", $time);
                error_count++;
            end else begin
                exp_e = expect_q.pop_front();
                check_value("eq_o", 16'(observed.value), 16'(exp_e.value));
                check_value("data_o", 16'(data_o), 16'(exp_e.data));
                check_value("data_valid_o latency", 16'(cycle_count - exp_e.sent_cycle),
                            16'(OUT_LATENCY));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_i = 1'b1;
        code_i = '0;
        code_valid_i = 1'b0;
        wt_we_i = 1'b0;
        wt_addr_i = '0;
        wt_data_i = '0;
        shift_we_i = 1'b0;
        shift_data_i = '0;
        seed = 51;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        model_win = '0;
        model_wts = identity_weights('0);
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // identity filter straight out of reset
        send_code(rx_dsp_pkg::code_t'(127), 1'b1);
        send_code(rx_dsp_pkg::code_t'(-128), 1'b1);
        send_code(rx_dsp_pkg::code_t'(0), 1'b1);
        send_code(rx_dsp_pkg::code_t'(1), 1'b1);
        send_code(rx_dsp_pkg::code_t'(-1), 1'b1);
        send_random(N_IDENT);
        drain_pipeline();

        // random taps, back-to-back codes
        load_weights(random_weights('0));
        send_random(N_RAND);
        drain_pipeline();

        // floor behavior of the shift on negative sums
        for (int s = 0; s < 4; s++) begin
            load_weights(random_weights(rx_dsp_pkg::shift_t'((s == 3) ? 15 : 2 * s + 1)));
            send_random(N_SHIFT);
            drain_pipeline();
        end

        // both clamp limits, with each sign of weight
        for (int c = 0; c < 4; c++) begin
            load_weights(uniform_weights(rx_dsp_pkg::weight_t'((c < 2) ? 127 : -128)));
            for (int i = 0; i < N_SAT; i++) begin
                send_code(rx_dsp_pkg::code_t'((c % 2 == 0) ? 127 : -128), 1'b1);
            end
            drain_pipeline();
        end

        // gaps in the valid strobe hold the window
        load_weights(random_weights(rx_dsp_pkg::shift_t'(2)));
        for (int i = 0; i < N_GAP; i++) begin
            send_code(rx_dsp_pkg::code_t'($random(seed)), (($random(seed) & 3) != 0));
        end
        drain_pipeline();

        // small values shifted to zero, and -3 floors to -1
        load_weights(identity_weights(rx_dsp_pkg::shift_t'(4)));
        send_code(rx_dsp_pkg::code_t'(5), 1'b1);
        send_code(rx_dsp_pkg::code_t'(-3), 1'b1);
        send_code(rx_dsp_pkg::code_t'(15), 1'b1);
        send_code(rx_dsp_pkg::code_t'(16), 1'b1);
        drain_pipeline();

        // difference filter, repeated codes cancel exactly
        model_wts = identity_weights('0);
        model_wts.tap[1] = rx_dsp_pkg::weight_t'(-1);
        load_weights(model_wts);
        for (int i = 0; i < N_ZERO - 4; i++) begin
            send_code(rx_dsp_pkg::code_t'((i < 4) ? 37 : -90), 1'b1);
        end
        drain_pipeline();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
